// File: design/div_pkg.sv
package div_pkg;

  // Operand and bus widths.
  localparam int unsigned XLEN   = 64;
  localparam int unsigned APB_AW = 8;
  localparam int unsigned APB_DW = 32;

  // Bit 0 selects unsigned, bit 1 selects remainder.
  typedef enum logic [1:0] {
    DivOpDiv  = 2'b00,
    DivOpDivu = 2'b01,
    DivOpRem  = 2'b10,
    DivOpRemu = 2'b11
  } div_op_e;

  // Register map, byte addresses.
  localparam logic [APB_AW-1:0] REG_A_LO   = 8'h00;
  localparam logic [APB_AW-1:0] REG_A_HI   = 8'h04;
  localparam logic [APB_AW-1:0] REG_B_LO   = 8'h08;
  localparam logic [APB_AW-1:0] REG_B_HI   = 8'h0C;
  localparam logic [APB_AW-1:0] REG_CTRL   = 8'h10;
  localparam logic [APB_AW-1:0] REG_STATUS = 8'h14;
  localparam logic [APB_AW-1:0] REG_RES_LO = 8'h18;
  localparam logic [APB_AW-1:0] REG_RES_HI = 8'h1C;

  // The op field sits in bits 1:0 of REG_CTRL.
  localparam int unsigned CTRL_WORD_BIT = 2;

  localparam int unsigned STAT_BUSY_BIT = 0;
  localparam int unsigned STAT_DONE_BIT = 1;

endpackage

// File: design/div_serial.sv
module div_serial (
  input  logic                      clk_i,
  input  logic                      rst_ni,

  input  logic [div_pkg::XLEN-1:0]  operand_a_i,
  input  logic [div_pkg::XLEN-1:0]  operand_b_i,
  input  div_pkg::div_op_e          req_op_i,
  input  logic                      req_word_i,
  input  logic                      req_valid_i,
  output logic                      req_ready_o,

  output logic [div_pkg::XLEN-1:0]  resp_value_o,
  output logic                      resp_valid_o
);

  import div_pkg::*;

  logic            op_unsigned;
  logic [XLEN-1:0] a_ext;
  logic [XLEN-1:0] b_ext;
  logic            a_sign;
  logic            b_sign;
  logic [XLEN-1:0] a_mag;
  logic [XLEN-1:0] b_mag;
  logic [XLEN-1:0] a_rev_full;
  logic [XLEN-1:0] a_rev;

  // Low is idle, high means an iteration is in progress.
  logic                    run_q, run_d;
  logic [$clog2(XLEN)-1:0] iter_q, iter_d;

  logic [XLEN-1:0] a_q, a_d;
  logic [XLEN-1:0] b_q, b_d;
  logic [XLEN-1:0] quo_q, quo_d;
  logic [XLEN-1:0] rem_q, rem_d;
  logic            quo_neg_q, quo_neg_d;
  logic            rem_neg_q, rem_neg_d;
  logic            word_q, word_d;
  logic            use_rem_q, use_rem_d;
  logic            out_valid;
  logic [XLEN-1:0] out_value;

  assign op_unsigned = req_op_i[0];

  // In word mode the low halves are extended first, so the rest of the
  // datapath sees a plain 64-bit value.
  always_comb begin
    if (req_word_i) begin
      a_ext = op_unsigned ? {{(XLEN/2){1'b0}}, operand_a_i[XLEN/2-1:0]}
                          : {{(XLEN/2){operand_a_i[XLEN/2-1]}}, operand_a_i[XLEN/2-1:0]};
      b_ext = op_unsigned ? {{(XLEN/2){1'b0}}, operand_b_i[XLEN/2-1:0]}
                          : {{(XLEN/2){operand_b_i[XLEN/2-1]}}, operand_b_i[XLEN/2-1:0]};
    end else begin
      a_ext = operand_a_i;
      b_ext = operand_b_i;
    end

    a_sign = !op_unsigned && a_ext[XLEN-1];
    b_sign = !op_unsigned && b_ext[XLEN-1];
    a_mag  = a_sign ? -a_ext : a_ext;
    b_mag  = b_sign ? -b_ext : b_ext;

    for (int i = 0; i < XLEN; i++) begin
      a_rev_full[i] = a_mag[XLEN-1-i];
    end
    // A word magnitude fits in the low half, so its reversed bits land high.
    a_rev = req_word_i ? (a_rev_full >> (XLEN/2)) : a_rev_full;
  end

  assign req_ready_o = !run_q;

  always_comb begin
    run_d     = run_q;
    iter_d    = iter_q;
    a_d       = a_q >> 1;
    b_d       = b_q;
    quo_d     = {quo_q[XLEN-2:0], 1'b0};
    rem_d     = {rem_q[XLEN-2:0], a_q[0]};
    quo_neg_d = quo_neg_q;
    rem_neg_d = rem_neg_q;
    word_d    = word_q;
    use_rem_d = use_rem_q;
    out_valid = 1'b0;
    out_value = '0;

    if (!run_q) begin
      if (req_valid_i) begin
        run_d     = 1'b1;
        iter_d    = req_word_i ? {1'b0, {($clog2(XLEN)-1){1'b1}}} : '1;
        a_d       = a_rev;
        b_d       = b_mag;
        quo_d     = '0;
        rem_d     = '0;
        // A zero divisor yields an all-ones quotient that must stay unsigned.
        quo_neg_d = (a_sign ^ b_sign) && (b_mag != '0);
        rem_neg_d = a_sign;
        word_d    = req_word_i;
        use_rem_d = req_op_i[1];
      end
    end else begin
      iter_d = iter_q - 1'b1;

      if (rem_d >= b_q) begin
        rem_d    = rem_d - b_q;
        quo_d[0] = 1'b1;
      end

      if (iter_q == '0) begin
        run_d     = 1'b0;
        out_valid = 1'b1;
        if (use_rem_q) begin
          out_value = rem_neg_q ? -rem_d : rem_d;
        end else begin
          out_value = quo_neg_q ? -quo_d : quo_d;
        end
        if (word_q) begin
          out_value = {{(XLEN/2){out_value[XLEN/2-1]}}, out_value[XLEN/2-1:0]};
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      run_q        <= 1'b0;
      iter_q       <= '0;
      resp_valid_o <= 1'b0;
    end else begin
      run_q        <= run_d;
      iter_q       <= iter_d;
      resp_valid_o <= out_valid;
    end
  end

  always_ff @(posedge clk_i) begin
    a_q       <= a_d;
    b_q       <= b_d;
    quo_q     <= quo_d;
    rem_q     <= rem_d;
    quo_neg_q <= quo_neg_d;
    rem_neg_q <= rem_neg_d;
    word_q    <= word_d;
    use_rem_q <= use_rem_d;
    if (out_valid) begin
      resp_value_o <= out_value;
    end
  end

  // The requester must wait for the divider to go idle.
  assert property (@(posedge clk_i) disable iff (!rst_ni) req_valid_i |-> req_ready_o);

  assert property (@(posedge clk_i) disable iff (!rst_ni) resp_valid_o |=> !resp_valid_o);

endmodule

// File: design/div_apb_regs.sv
module div_apb_regs (
  input  logic                        clk_i,
  input  logic                        rst_ni,

  input  logic                        psel_i,
  input  logic                        penable_i,
  input  logic                        pwrite_i,
  input  logic [div_pkg::APB_AW-1:0]  paddr_i,
  input  logic [div_pkg::APB_DW-1:0]  pwdata_i,
  output logic [div_pkg::APB_DW-1:0]  prdata_o,
  output logic                        pready_o,
  output logic                        pslverr_o,

  output logic [div_pkg::XLEN-1:0]    div_a_o,
  output logic [div_pkg::XLEN-1:0]    div_b_o,
  output div_pkg::div_op_e            div_op_o,
  output logic                        div_word_o,
  output logic                        div_valid_o,
  input  logic                        div_ready_i,
  input  logic [div_pkg::XLEN-1:0]    div_value_i,
  input  logic                        div_resp_valid_i
);

  import div_pkg::*;

  logic            access;
  logic            addr_ok;
  logic            ctrl_err;
  logic            wr_ok;
  logic            start;

  logic [XLEN-1:0] a_q;
  logic [XLEN-1:0] b_q;
  logic [XLEN-1:0] res_q;
  div_op_e         op_q;
  logic            word_q;
  logic            busy_q;
  logic            done_q;
  logic            valid_q;

  assign access = psel_i && penable_i;

  // Read data and address check come straight from the address.
  always_comb begin
    addr_ok  = 1'b1;
    prdata_o = '0;
    case (paddr_i)
      REG_A_LO:   prdata_o = a_q[APB_DW-1:0];
      REG_A_HI:   prdata_o = a_q[XLEN-1:APB_DW];
      REG_B_LO:   prdata_o = b_q[APB_DW-1:0];
      REG_B_HI:   prdata_o = b_q[XLEN-1:APB_DW];
      REG_CTRL: begin
        prdata_o[1:0]          = op_q;
        prdata_o[CTRL_WORD_BIT] = word_q;
      end
      REG_STATUS: begin
        prdata_o[STAT_BUSY_BIT] = busy_q;
        prdata_o[STAT_DONE_BIT] = done_q;
      end
      REG_RES_LO: prdata_o = res_q[APB_DW-1:0];
      REG_RES_HI: prdata_o = res_q[XLEN-1:APB_DW];
      default:    addr_ok = 1'b0;
    endcase
  end

  // A new division cannot be started over one that is still running.
  assign ctrl_err  = pwrite_i && (paddr_i == REG_CTRL) && busy_q;
  assign pslverr_o = access && (!addr_ok || ctrl_err);
  assign pready_o  = 1'b1;

  assign wr_ok = access && pwrite_i && !pslverr_o;
  assign start = wr_ok && (paddr_i == REG_CTRL);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      a_q     <= '0;
      b_q     <= '0;
      res_q   <= '0;
      op_q    <= DivOpDiv;
      word_q  <= 1'b0;
      busy_q  <= 1'b0;
      done_q  <= 1'b0;
      valid_q <= 1'b0;
    end else begin
      valid_q <= start;

      if (wr_ok) begin
        case (paddr_i)
          REG_A_LO: a_q[APB_DW-1:0]    <= pwdata_i;
          REG_A_HI: a_q[XLEN-1:APB_DW] <= pwdata_i;
          REG_B_LO: b_q[APB_DW-1:0]    <= pwdata_i;
          REG_B_HI: b_q[XLEN-1:APB_DW] <= pwdata_i;
          default: ;
        endcase
      end

      if (start) begin
        op_q   <= div_op_e'(pwdata_i[1:0]);
        word_q <= pwdata_i[CTRL_WORD_BIT];
        busy_q <= 1'b1;
        done_q <= 1'b0;
      end

      if (div_resp_valid_i) begin
        res_q  <= div_value_i;
        busy_q <= 1'b0;
        done_q <= 1'b1;
      end
    end
  end

  assign div_a_o     = a_q;
  assign div_b_o     = b_q;
  assign div_op_o    = op_q;
  assign div_word_o  = word_q;
  assign div_valid_o = valid_q;

  // The request is only raised once the divider has gone idle.
  assert property (@(posedge clk_i) disable iff (!rst_ni) div_valid_o |-> div_ready_i);

  assert property (@(posedge clk_i) disable iff (!rst_ni) div_resp_valid_i |-> busy_q);

endmodule

// File: design/div_unit_top.sv
module div_unit_top (
  input  logic                        clk_i,
  input  logic                        rst_ni,

  input  logic                        psel_i,
  input  logic                        penable_i,
  input  logic                        pwrite_i,
  input  logic [div_pkg::APB_AW-1:0]  paddr_i,
  input  logic [div_pkg::APB_DW-1:0]  pwdata_i,
  output logic [div_pkg::APB_DW-1:0]  prdata_o,
  output logic                        pready_o,
  output logic                        pslverr_o
);

  import div_pkg::*;

  logic [XLEN-1:0] div_a;
  logic [XLEN-1:0] div_b;
  div_op_e         div_op;
  logic            div_word;
  logic            div_valid;
  logic            div_ready;
  logic [XLEN-1:0] div_value;
  logic            div_resp_valid;

  div_apb_regs i_regs (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .psel_i          (psel_i),
    .penable_i       (penable_i),
    .pwrite_i        (pwrite_i),
    .paddr_i         (paddr_i),
    .pwdata_i        (pwdata_i),
    .prdata_o        (prdata_o),
    .pready_o        (pready_o),
    .pslverr_o       (pslverr_o),
    .div_a_o         (div_a),
    .div_b_o         (div_b),
    .div_op_o        (div_op),
    .div_word_o      (div_word),
    .div_valid_o     (div_valid),
    .div_ready_i     (div_ready),
    .div_value_i     (div_value),
    .div_resp_valid_i(div_resp_valid)
  );

  div_serial i_div (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .operand_a_i (div_a),
    .operand_b_i (div_b),
    .req_op_i    (div_op),
    .req_word_i  (div_word),
    .req_valid_i (div_valid),
    .req_ready_o (div_ready),
    .resp_value_o(div_value),
    .resp_valid_o(div_resp_valid)
  );

endmodule

// File: test/div_tb.sv
module div_tb;

  import div_pkg::*;

  localparam int CLK_PERIOD = 100;

  localparam logic [XLEN-1:0] ALL_ONES = '1;
  localparam logic [XLEN-1:0] MIN_NEG  = 64'h8000_0000_0000_0000;
  localparam logic [XLEN-1:0] NEG100   = 64'hFFFF_FFFF_FFFF_FF9C;
  localparam logic [XLEN-1:0] NEG14    = 64'hFFFF_FFFF_FFFF_FFF2;
  localparam logic [XLEN-1:0] NEG7     = 64'hFFFF_FFFF_FFFF_FFF9;
  localparam logic [XLEN-1:0] NEG2     = 64'hFFFF_FFFF_FFFF_FFFE;

  logic              clk;
  logic              rst_n;
  logic              psel;
  logic              penable;
  logic              pwrite;
  logic [APB_AW-1:0] paddr;
  logic [APB_DW-1:0] pwdata;
  logic [APB_DW-1:0] prdata;
  logic              pready;
  logic              pslverr;

  logic [XLEN-1:0] vec_a[$];
  logic [XLEN-1:0] vec_b[$];
  div_op_e         vec_op[$];
  logic            vec_word[$];
  logic [XLEN-1:0] vec_exp[$];
  bit              table_ready = 1'b0;
  integer          seed = 8875;

  div_unit_top i_dut (
    .clk_i    (clk),
    .rst_ni   (rst_n),
    .psel_i   (psel),
    .penable_i(penable),
    .pwrite_i (pwrite),
    .paddr_i  (paddr),
    .pwdata_i (pwdata),
    .prdata_o (prdata),
    .pready_o (pready),
    .pslverr_o(pslverr)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  task automatic abort_run(input string what);
    $display("Error: %s", what);
    $display("TEST FAILED");
    $fatal(1, what);
  endtask

  task automatic check_result(input string name, input logic [XLEN-1:0] exp,
                              input logic [XLEN-1:0] act);
    if (act !== exp) begin
      $display("** Error: %s expected 0x%h, got 0x%h", name, exp, act);
      $display("TEST FAILED");
      $fatal(1, "result mismatch");
    end
  endtask

  task automatic check_reg(input string name, input logic [APB_DW-1:0] exp,
                           input logic [APB_DW-1:0] act);
    if (act !== exp) begin
      $display("** Error: %s expected 0x%h, got 0x%h", name, exp, act);
      $display("TEST FAILED");
      $fatal(1, "register mismatch");
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("** Error: %s expected 0x%h, got 0x%h", name, exp, act);
      $display("TEST FAILED");
      $fatal(1, "flag mismatch");
    end
  endtask

  // One APB transfer runs a setup phase and an access phase and then goes idle.
  // Outputs are sampled in the middle of the access phase.
  task automatic apb_access(input logic write, input logic [APB_AW-1:0] addr,
                            input logic [APB_DW-1:0] wdata,
                            output logic [APB_DW-1:0] rdata, output logic err);
    @(posedge clk);
    #10;
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = write;
    paddr   = addr;
    pwdata  = wdata;
    @(posedge clk);
    #10;
    penable = 1'b1;
    #40;
    rdata = prdata;
    err   = pslverr;
    check_flag("pready", 1'b1, pready);
    @(posedge clk);
    #10;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_write(input logic [APB_AW-1:0] addr, input logic [APB_DW-1:0] data,
                           output logic err);
    logic [APB_DW-1:0] ignored;
    apb_access(1'b1, addr, data, ignored, err);
  endtask

  task automatic apb_read(input logic [APB_AW-1:0] addr, output logic [APB_DW-1:0] data,
                          output logic err);
    apb_access(1'b0, addr, '0, data, err);
  endtask

  task automatic write_ok(input logic [APB_AW-1:0] addr, input logic [APB_DW-1:0] data);
    logic err;
    apb_write(addr, data, err);
    check_flag("pslverr", 1'b0, err);
  endtask

  task automatic read_ok(input logic [APB_AW-1:0] addr, output logic [APB_DW-1:0] data);
    logic err;
    apb_read(addr, data, err);
    check_flag("pslverr", 1'b0, err);
  endtask

  task automatic start_division(input logic [XLEN-1:0] a, input logic [XLEN-1:0] b,
                                input div_op_e op, input logic word);
    logic [APB_DW-1:0] ctrl;
    ctrl                = '0;
    ctrl[1:0]           = op;
    ctrl[CTRL_WORD_BIT] = word;
    write_ok(REG_A_LO, a[APB_DW-1:0]);
    write_ok(REG_A_HI, a[XLEN-1:APB_DW]);
    write_ok(REG_B_LO, b[APB_DW-1:0]);
    write_ok(REG_B_HI, b[XLEN-1:APB_DW]);
    write_ok(REG_CTRL, ctrl);
  endtask

  task automatic wait_done();
    logic [APB_DW-1:0] status;
    int                polls;
    polls  = 0;
    status = '0;
    while (!status[STAT_DONE_BIT]) begin
      if (polls == 200) begin
        abort_run("divider never reported done");
      end
      read_ok(REG_STATUS, status);
      polls++;
    end
    // Capturing the response also ends busy.
    check_flag("busy", 1'b0, status[STAT_BUSY_BIT]);
  endtask

  task automatic read_result(output logic [XLEN-1:0] res);
    logic [APB_DW-1:0] lo;
    logic [APB_DW-1:0] hi;
    read_ok(REG_RES_LO, lo);
    read_ok(REG_RES_HI, hi);
    res = {hi, lo};
  endtask

  task automatic add_vec(input logic [XLEN-1:0] a, input logic [XLEN-1:0] b,
                         input div_op_e op, input logic word, input logic [XLEN-1:0] exp);
    vec_a.push_back(a);
    vec_b.push_back(b);
    vec_op.push_back(op);
    vec_word.push_back(word);
    vec_exp.push_back(exp);
  endtask

  task automatic build_table();
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    // Signed doubleword over every sign combination.
    add_vec(64'd100, 64'd7, DivOpDiv, 1'b0, 64'd14);
    add_vec(NEG100, 64'd7, DivOpDiv, 1'b0, NEG14);
    add_vec(64'd100, NEG7, DivOpDiv, 1'b0, NEG14);
    add_vec(NEG100, NEG7, DivOpDiv, 1'b0, 64'd14);
    add_vec(64'd100, 64'd7, DivOpRem, 1'b0, 64'd2);
    add_vec(NEG100, 64'd7, DivOpRem, 1'b0, NEG2);
    add_vec(64'd100, NEG7, DivOpRem, 1'b0, 64'd2);
    add_vec(NEG100, NEG7, DivOpRem, 1'b0, NEG2);
    // Unsigned doubleword sees the top bit as magnitude.
    add_vec(64'd100, 64'd7, DivOpDivu, 1'b0, 64'd14);
    add_vec(64'd100, 64'd7, DivOpRemu, 1'b0, 64'd2);
    add_vec(64'd100, NEG7, DivOpDivu, 1'b0, 64'd0);
    add_vec(64'd100, NEG7, DivOpRemu, 1'b0, 64'd100);
    add_vec(ALL_ONES, 64'h10, DivOpDivu, 1'b0, 64'h0FFF_FFFF_FFFF_FFFF);
    add_vec(ALL_ONES, 64'h10, DivOpRemu, 1'b0, 64'hF);
    add_vec(MIN_NEG, ALL_ONES, DivOpDivu, 1'b0, 64'd0);
    add_vec(MIN_NEG, ALL_ONES, DivOpRemu, 1'b0, MIN_NEG);
    add_vec(MIN_NEG, ALL_ONES, DivOpDiv, 1'b0, MIN_NEG);
    add_vec(MIN_NEG, ALL_ONES, DivOpRem, 1'b0, 64'd0);
    // Division by zero.
    add_vec(NEG100, 64'd0, DivOpDiv, 1'b0, ALL_ONES);
    add_vec(64'd100, 64'd0, DivOpDivu, 1'b0, ALL_ONES);
    add_vec(NEG100, 64'd0, DivOpRem, 1'b0, NEG100);
    add_vec(64'd100, 64'd0, DivOpRemu, 1'b0, 64'd100);
    // Word forms with junk in the upper operand halves.
    add_vec(64'hDEAD_BEEF_FFFF_FF9C, 64'h1234_5678_0000_0007, DivOpDiv, 1'b1, NEG14);
    add_vec(64'hDEAD_BEEF_FFFF_FF9C, 64'h1234_5678_0000_0007, DivOpRem, 1'b1, NEG2);
    add_vec(64'h0123_4567_FFFF_FFFF, 64'hFFFF_FFFF_0000_0001, DivOpDivu, 1'b1, ALL_ONES);
    add_vec(64'h0123_4567_FFFF_FFFF, 64'h0000_0001_0000_0010, DivOpRemu, 1'b1, 64'hF);
    add_vec(64'h0000_0001_8000_0000, 64'hABCD_0000_FFFF_FFFF, DivOpDiv, 1'b1,
            64'hFFFF_FFFF_8000_0000);
    add_vec(64'h0000_0001_8000_0000, 64'hABCD_0000_FFFF_FFFF, DivOpRem, 1'b1, 64'd0);
    add_vec(64'h0000_0000_0000_0005, 64'hFFFF_0000_0000_0000, DivOpDiv, 1'b1, ALL_ONES);
    add_vec(64'h7777_7777_FFFF_FF9C, 64'hFFFF_0000_0000_0000, DivOpRem, 1'b1, NEG100);
    add_vec(64'h5555_0000_8000_0000, 64'hFFFF_0000_0000_0000, DivOpRemu, 1'b1,
            64'hFFFF_FFFF_8000_0000);
    add_vec(64'h5555_0000_8000_0000, 64'h0000_0001_0000_0002, DivOpDivu, 1'b1,
            64'h0000_0000_4000_0000);
    for (int i = 0; i < 4; i++) begin
      a = {$random(seed), $random(seed)};
      b = (i % 2 == 1) ? {32'h0, $random(seed)} : {$random(seed), $random(seed)};
      if (b == '0) begin
        b = 64'd1;
      end
      if (i % 2 == 1) begin
        add_vec(a, b, DivOpRemu, 1'b0, a % b);
      end else begin
        add_vec(a, b, DivOpDivu, 1'b0, a / b);
      end
    end
  endtask

  initial begin
    wait (table_ready);
    repeat ((vec_a.size() + 1) * 120 + 200) @(posedge clk);
    abort_run("watchdog expired before the tests completed");
  end

  initial begin
    logic [XLEN-1:0]   res;
    logic [APB_DW-1:0] rdata;
    logic              err;
    clk     = 1'b0;
    rst_n   = 1'b0;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = '0;
    pwdata  = '0;
    build_table();
    table_ready = 1'b1;
    repeat (5) @(posedge clk);
    #10;
    rst_n = 1'b1;

    read_ok(REG_STATUS, rdata);
    check_reg("status", '0, rdata);
    read_ok(REG_RES_LO, rdata);
    check_reg("res_lo", '0, rdata);
    read_ok(REG_RES_HI, rdata);
    check_reg("res_hi", '0, rdata);

    foreach (vec_a[i]) begin
      start_division(vec_a[i], vec_b[i], vec_op[i], vec_word[i]);
      wait_done();
      read_result(res);
      check_result($sformatf("result[%0d]", i), vec_exp[i], res);
    end

    // A second start while busy is refused and leaves the running division alone.
    start_division(ALL_ONES, 64'd3, DivOpDivu, 1'b0);
    apb_write(REG_CTRL, 32'(DivOpRemu), err);
    check_flag("pslverr", 1'b1, err);
    read_ok(REG_STATUS, rdata);
    check_reg("status", 32'h1 << STAT_BUSY_BIT, rdata);
    read_ok(REG_CTRL, rdata);
    check_reg("ctrl", 32'(DivOpDivu), rdata);
    apb_read(8'h20, rdata, err);
    check_flag("pslverr", 1'b1, err);
    wait_done();
    read_result(res);
    check_result("result_busy", 64'h5555_5555_5555_5555, res);

    $display("TEST PASSED");
    $finish;
  end

endmodule

// File: vlog.f
design/div_pkg.sv
design/div_serial.sv
design/div_apb_regs.sv
design/div_unit_top.sv
test/div_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the divide unit testbench with Verilator and runs it.
set -e

cd "$(dirname "$0")"

verilator --binary --assert --top-module div_tb -f vlog.f -o div_tb_sim

./obj_dir/div_tb_sim > sim.log 2>&1

if grep -q "TEST FAILED" sim.log; then
  echo "Simulation failed, see sim.log"
  exit 1
fi

echo "Simulation finished without failures, see sim.log"
